//--- Makefile
# Verilator build and run for the pad ring testbench

VERILATOR   ?= verilator
TOP         ?= tb_chip_io
FILELIST    ?= src.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert

PASS_MSG := *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/pad_ctrl_if.sv
`timescale 1ns/10ps

// Core-side controls of one pad bank and the input data it returns
interface pad_ctrl_if #(
	parameter int WIDTH = 1
);

	logic [WIDTH-1:0] out;
	logic [WIDTH-1:0] oeb;
	logic [WIDTH-1:0] ieb;
	// Pad i takes bits [DM_BITS*i +: DM_BITS] of the packed modes
	logic [WIDTH*pad_pkg::DM_BITS-1:0] dm;
	logic [WIDTH-1:0] in;

	modport core (
		output out,
		output oeb,
		output ieb,
		output dm,
		input  in
	);

	modport pad (
		input  out,
		input  oeb,
		input  ieb,
		input  dm,
		output in
	);

endinterface

//--- common/pad_pkg.sv
package pad_pkg;

	// Drive mode of one pad as the core sets it
	// Codes not listed here behave like PAD_DM_OFF
	typedef enum logic [2:0] {
		PAD_DM_OFF         = 3'b000,
		PAD_DM_INPUT       = 3'b001,
		PAD_DM_OPEN_DRAIN  = 3'b100,
		PAD_DM_STRONG      = 3'b110,
		PAD_DM_STRONG_SLOW = 3'b111
	} pad_dm_e;

	// Mode bits per pad in a packed mode vector
	localparam int DM_BITS = $bits(pad_dm_e);

	// GPIO bank pin count
	localparam int GPIO_PADS = 16;

	// Quad-SPI flash data pins
	localparam int FLASH_IO_PADS = 4;

	// Default user-project pad count
	localparam int MPRJ_IO_PADS = 32;

	// Stable cycles the external reset must hold before porb follows it
	localparam int XRES_FILTER_CYCLES = 8;

endpackage

//--- mprj/mprj_io_ring.sv
`timescale 1ns/10ps

module mprj_io_ring #(
	parameter int PADS        = 32,
	parameter int SYNC_STAGES = 2
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [PADS-1:0]                  ext,
	input  logic [PADS-1:0]                  io_out,
	input  logic [PADS-1:0]                  io_oeb,
	input  logic [PADS-1:0]                  hldh_n,
	input  logic [PADS-1:0]                  enh,
	input  logic [PADS-1:0]                  inp_dis,
	input  logic [PADS*pad_pkg::DM_BITS-1:0] dm,
	output logic [PADS-1:0]                  pad_out,
	output logic [PADS-1:0]                  pad_oe,
	output logic [PADS-1:0]                  io_in
);

	localparam int DMW = pad_pkg::DM_BITS;

	// Values captured while hold is released
	logic [PADS-1:0]     hold_out;
	logic [PADS-1:0]     hold_oeb;
	logic [PADS-1:0]     hold_enh;
	logic [PADS*DMW-1:0] hold_dm;

	// Live or held set as chosen per pad
	logic [PADS-1:0]     sel_out;
	logic [PADS-1:0]     sel_oeb;
	logic [PADS-1:0]     sel_enh;
	logic [PADS*DMW-1:0] sel_dm;

	pad_ctrl_if #(.WIDTH(PADS)) ring_ctrl ();

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hold_out <= '0;
			hold_oeb <= '1;
			hold_enh <= '0;
			hold_dm  <= {PADS{pad_pkg::PAD_DM_OFF}};
		end else begin
			for (int i = 0; i < PADS; i++) begin
				if (hldh_n[i]) begin
					hold_out[i]          <= io_out[i];
					hold_oeb[i]          <= io_oeb[i];
					hold_enh[i]          <= enh[i];
					hold_dm[DMW*i +: DMW] <= dm[DMW*i +: DMW];
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < PADS; i++) begin
			sel_out[i]           = hldh_n[i] ? io_out[i] : hold_out[i];
			sel_oeb[i]           = hldh_n[i] ? io_oeb[i] : hold_oeb[i];
			sel_enh[i]           = hldh_n[i] ? enh[i] : hold_enh[i];
			sel_dm[DMW*i +: DMW] = hldh_n[i] ? dm[DMW*i +: DMW] : hold_dm[DMW*i +: DMW];
			// A disabled pad is parked in mode off
			ring_ctrl.dm[DMW*i +: DMW] = sel_enh[i] ? sel_dm[DMW*i +: DMW]
				: pad_pkg::PAD_DM_OFF;
		end
	end

	assign ring_ctrl.out = sel_out;
	assign ring_ctrl.oeb = sel_oeb;
	assign ring_ctrl.ieb = inp_dis;

	pad_bank #(
		.WIDTH       (PADS),
		.SYNC_STAGES (SYNC_STAGES)
	) i_pads (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (ring_ctrl.pad),
		.ext     (ext),
		.pad_out (pad_out),
		.pad_oe  (pad_oe)
	);

	assign io_in = ring_ctrl.in;

endmodule

//--- src.f
common/pad_pkg.sv
common/pad_ctrl_if.sv
verilog/pad_bank.sv
verilog/xres_filter.sv
mprj/mprj_io_ring.sv
verilog/chip_io.sv
tests/chip_io_chk.sv
tests/tb_chip_io.sv

//--- tests/chip_io_chk.sv
`timescale 1ns/10ps

module chip_io_chk #(
	parameter int PADS = 32
) (
	input logic                          clk,
	input logic                          rst_n,
	input logic [pad_pkg::GPIO_PADS-1:0] gpio_pad_oe,
	input logic [pad_pkg::GPIO_PADS-1:0] gpio_outenb_core,
	input logic                          porb,
	input logic [PADS-1:0]               mprj_pad_oe,
	input logic [PADS-1:0]               mprj_sel_enh
);

	// Count of assertion failures, read by the testbench at the end
	int assert_fails = 0;

	// A GPIO pad never drives while its output is disabled
	a_gpio_oe: assert property (@(posedge clk) disable iff (!rst_n)
		(gpio_pad_oe & gpio_outenb_core) == '0)
		else begin
			assert_fails++;
			$error("gpio pad drives while its output is disabled");
		end

	// Core reset stays asserted right after the pad ring reset
	a_porb_reset: assert property (@(posedge clk) !rst_n |=> !porb)
		else begin
			assert_fails++;
			$error("porb high in the cycle after reset");
		end

	// A disabled user-project pad never drives
	a_mprj_enh: assert property (@(posedge clk) disable iff (!rst_n)
		(mprj_pad_oe & ~mprj_sel_enh) == '0)
		else begin
			assert_fails++;
			$error("user-project pad drives with enh cleared");
		end

endmodule

bind chip_io chip_io_chk #(.PADS(MPRJ_PADS)) i_chk (
	.clk              (clk),
	.rst_n            (rst_n),
	.gpio_pad_oe      (gpio_pad_oe),
	.gpio_outenb_core (gpio_outenb_core),
	.porb             (porb),
	.mprj_pad_oe      (mprj_pad_oe),
	.mprj_sel_enh     (i_mprj.sel_enh)
);

//--- tests/tb_chip_io.sv
`timescale 1ns/10ps

module tb_chip_io;

	localparam int GPIO_W         = pad_pkg::GPIO_PADS;
	localparam int FLASH_W        = pad_pkg::FLASH_IO_PADS;
	localparam int MPRJ_W         = pad_pkg::MPRJ_IO_PADS;
	localparam int DMW            = pad_pkg::DM_BITS;
	localparam int FILTER         = pad_pkg::XRES_FILTER_CYCLES;
	localparam int GPIO_SYNC      = 2;
	localparam int FLASH_SYNC     = 1;
	localparam int MPRJ_SYNC      = 2;
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk = 1'b0;
	logic rst_n;
	logic [GPIO_W-1:0] gpio_ext, gpio_out_core, gpio_mode0_core, gpio_mode1_core;
	logic [GPIO_W-1:0] gpio_outenb_core, gpio_inenb_core;
	logic [GPIO_W-1:0] gpio_pad_out, gpio_pad_oe, gpio_in_core;
	logic [FLASH_W-1:0] flash_io_ext, flash_io_do_core, flash_io_oeb_core, flash_io_ieb_core;
	logic [FLASH_W-1:0] flash_io_pad_out, flash_io_pad_oe, flash_io_di_core;
	logic rstb_ext;
	logic porb;
	logic [MPRJ_W-1:0] mprj_ext, mprj_io_out, mprj_io_oeb, mprj_io_hldh_n;
	logic [MPRJ_W-1:0] mprj_io_enh, mprj_io_inp_dis;
	logic [MPRJ_W*DMW-1:0] mprj_io_dm;
	logic [MPRJ_W-1:0] mprj_pad_out, mprj_pad_oe, mprj_io_in;
	int cycle_count = 0;

	chip_io #(
		.GPIO_SYNC     (GPIO_SYNC),
		.FLASH_SYNC    (FLASH_SYNC),
		.MPRJ_SYNC     (MPRJ_SYNC),
		.MPRJ_PADS     (MPRJ_W),
		.FILTER_CYCLES (FILTER)
	) i_dut (.*);

	always #4 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run("Timeout: the tests did not finish within the cycle limit");
		end
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected));
		end
	endtask

	// Let some rising edges pass and look at the outputs between edges
	task automatic sample_after(input int edges);
		repeat (edges) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic test_gpio_modes;
		logic [GPIO_W-1:0] data;
		logic [GPIO_W-1:0] oeb;
		logic [GPIO_W-1:0] m1;
		logic [GPIO_W-1:0] m0;
		logic [MPRJ_W-1:0] od_data;
		logic [MPRJ_W-1:0] od_oe;

		for (int r = 0; r < 8; r++) begin
			data = GPIO_W'($urandom);
			oeb  = GPIO_W'($urandom);
			// All four mode pairs on every pin first and mixed pins after
			m1   = (r < 4) ? {GPIO_W{r[1]}} : GPIO_W'($urandom);
			m0   = (r < 4) ? {GPIO_W{r[0]}} : GPIO_W'($urandom);
			@(posedge clk);
			gpio_out_core    <= data;
			gpio_outenb_core <= oeb;
			gpio_mode1_core  <= m1;
			gpio_mode0_core  <= m0;
			@(negedge clk);
			// mode1 set means strong or strong-slow and clear means off or input
			check_value("gpio_pad_oe", 64'(gpio_pad_oe), 64'(m1 & ~oeb));
			check_value("gpio_pad_out", 64'(gpio_pad_out), 64'(data));
		end

		// Open drain only reachable through the user-project mode bits
		od_data = MPRJ_W'($urandom);
		od_oe   = ~od_data;
		@(posedge clk);
		mprj_io_hldh_n <= '1;
		mprj_io_enh    <= '1;
		mprj_io_oeb    <= '0;
		mprj_io_out    <= od_data;
		mprj_io_dm     <= {MPRJ_W{pad_pkg::PAD_DM_OPEN_DRAIN}};
		@(negedge clk);
		check_value("open drain pad_oe", 64'(mprj_pad_oe), 64'(od_oe));
		check_value("open drain pad_out", 64'(mprj_pad_out), 64'(od_data));
	endtask

	task automatic test_gpio_input;
		logic [GPIO_W-1:0] v;
		logic [GPIO_W-1:0] w;

		v = GPIO_W'($urandom) | GPIO_W'(1);
		w = GPIO_W'($urandom);
		@(posedge clk);
		gpio_outenb_core <= '1;
		gpio_inenb_core  <= '0;
		gpio_mode1_core  <= '0;
		gpio_mode0_core  <= '1;
		gpio_ext         <= '0;
		sample_after(GPIO_SYNC + 1);
		check_value("gpio_in_core idle", 64'(gpio_in_core), 64'(0));
		@(posedge clk);
		gpio_ext <= v;
		sample_after(GPIO_SYNC - 1);
		check_value("gpio_in_core one edge early", 64'(gpio_in_core), 64'(0));
		sample_after(1);
		check_value("gpio_in_core", 64'(gpio_in_core), 64'(v));
		@(posedge clk);
		gpio_inenb_core <= '1;
		sample_after(GPIO_SYNC);
		check_value("gpio_in_core inenb", 64'(gpio_in_core), 64'(0));
		@(posedge clk);
		gpio_inenb_core <= '0;
		gpio_mode0_core <= '0;
		sample_after(GPIO_SYNC);
		check_value("gpio_in_core mode off", 64'(gpio_in_core), 64'(0));
		// Strong drive reads back its own level over the board value
		@(posedge clk);
		gpio_mode1_core  <= '1;
		gpio_outenb_core <= '0;
		gpio_out_core    <= w;
		gpio_ext         <= ~w;
		sample_after(GPIO_SYNC);
		check_value("gpio_in_core readback", 64'(gpio_in_core), 64'(w));
	endtask

	task automatic test_flash;
		logic [FLASH_W-1:0] v;
		logic [FLASH_W-1:0] d;

		v = FLASH_W'($urandom) | FLASH_W'(1);
		d = FLASH_W'($urandom);
		@(posedge clk);
		flash_io_oeb_core <= '1;
		flash_io_ieb_core <= '0;
		flash_io_ext      <= '0;
		sample_after(FLASH_SYNC + 1);
		check_value("flash_io_di_core idle", 64'(flash_io_di_core), 64'(0));
		check_value("flash_io_pad_oe input", 64'(flash_io_pad_oe), 64'(0));
		@(posedge clk);
		flash_io_ext <= v;
		sample_after(FLASH_SYNC - 1);
		check_value("flash_io_di_core early", 64'(flash_io_di_core), 64'(0));
		sample_after(1);
		check_value("flash_io_di_core", 64'(flash_io_di_core), 64'(v));
		@(posedge clk);
		flash_io_oeb_core <= '0;
		flash_io_ieb_core <= '1;
		flash_io_do_core  <= d;
		sample_after(0);
		check_value("flash_io_pad_oe output", 64'(flash_io_pad_oe), 64'({FLASH_W{1'b1}}));
		check_value("flash_io_pad_out", 64'(flash_io_pad_out), 64'(d));
	endtask

	// Wait for porb to reach a level and return the edges it took
	task automatic wait_porb(input logic level, output int edges);
		edges = 0;
		while (porb !== level) begin
			if (edges > FILTER + 8) begin
				fail_run("porb never followed the external reset pin");
			end
			sample_after(1);
			edges++;
		end
	endtask

	task automatic test_reset_filter;
		int edges;

		repeat (4) begin
			sample_after(1);
			check_value("porb after reset", 64'(porb), 64'(0));
		end
		@(posedge clk);
		rstb_ext <= 1'b1;
		@(negedge clk);
		wait_porb(1'b1, edges);
		if (edges < 2 + FILTER) begin
			fail_run("porb rose before the filter time had passed");
		end
		// Low pulse one cycle shorter than the filter
		@(posedge clk);
		rstb_ext <= 1'b0;
		repeat (FILTER - 1) @(posedge clk);
		rstb_ext <= 1'b1;
		repeat (FILTER + 6) begin
			sample_after(1);
			check_value("porb after glitch", 64'(porb), 64'(1));
		end
		@(posedge clk);
		rstb_ext <= 1'b0;
		@(negedge clk);
		wait_porb(1'b0, edges);
		if (edges < 2 + FILTER) begin
			fail_run("porb fell before the filter time had passed");
		end
		@(posedge clk);
		rstb_ext <= 1'b1;
	endtask

	task automatic test_mprj_hold;
		logic [MPRJ_W-1:0] a_out;
		logic [MPRJ_W-1:0] a_oeb;
		logic [MPRJ_W-1:0] a_oe;
		logic [MPRJ_W-1:0] v;
		logic [MPRJ_W-1:0] c;

		a_out = MPRJ_W'($urandom);
		a_oeb = MPRJ_W'($urandom);
		a_oe  = ~a_oeb;
		v     = MPRJ_W'($urandom) | MPRJ_W'(1);
		c     = MPRJ_W'($urandom) | MPRJ_W'(1);
		@(posedge clk);
		mprj_io_hldh_n  <= '1;
		mprj_io_enh     <= '1;
		mprj_io_inp_dis <= '0;
		mprj_io_dm      <= {MPRJ_W{pad_pkg::PAD_DM_STRONG}};
		mprj_io_out     <= a_out;
		mprj_io_oeb     <= a_oeb;
		sample_after(0);
		check_value("mprj_pad_oe live", 64'(mprj_pad_oe), 64'(a_oe));
		check_value("mprj_pad_out live", 64'(mprj_pad_out), 64'(a_out));
		@(posedge clk);
		mprj_io_hldh_n <= '0;
		@(posedge clk);
		mprj_io_out <= MPRJ_W'($urandom);
		mprj_io_oeb <= MPRJ_W'($urandom);
		mprj_io_dm  <= '0;
		mprj_io_enh <= '0;
		sample_after(0);
		check_value("mprj_pad_oe held", 64'(mprj_pad_oe), 64'(a_oe));
		check_value("mprj_pad_out held", 64'(mprj_pad_out), 64'(a_out));
		sample_after(3);
		check_value("mprj_pad_oe still held", 64'(mprj_pad_oe), 64'(a_oe));
		check_value("mprj_pad_out still held", 64'(mprj_pad_out), 64'(a_out));
		@(posedge clk);
		mprj_io_hldh_n <= '1;
		sample_after(0);
		check_value("mprj_pad_oe released", 64'(mprj_pad_oe), 64'(0));
		@(posedge clk);
		mprj_io_enh <= '1;
		mprj_io_dm  <= {MPRJ_W{pad_pkg::PAD_DM_INPUT}};
		mprj_io_oeb <= '1;
		mprj_ext    <= v;
		sample_after(MPRJ_SYNC);
		check_value("mprj_io_in", 64'(mprj_io_in), 64'(v));
		// Input disable blocks the board value
		@(posedge clk);
		mprj_io_inp_dis <= '1;
		sample_after(MPRJ_SYNC);
		check_value("mprj_io_in inp_dis", 64'(mprj_io_in), 64'(0));
		@(posedge clk);
		mprj_io_inp_dis <= '0;
		@(posedge clk);
		mprj_io_dm  <= {MPRJ_W{pad_pkg::PAD_DM_STRONG}};
		mprj_io_oeb <= '0;
		mprj_io_out <= c;
		sample_after(MPRJ_SYNC);
		check_value("mprj_pad_oe strong", 64'(mprj_pad_oe), 64'({MPRJ_W{1'b1}}));
		check_value("mprj_io_in readback", 64'(mprj_io_in), 64'(c));
		@(posedge clk);
		mprj_io_enh <= '0;
		sample_after(0);
		check_value("mprj_pad_oe enh off", 64'(mprj_pad_oe), 64'(0));
		sample_after(MPRJ_SYNC);
		check_value("mprj_io_in enh off", 64'(mprj_io_in), 64'(0));
	endtask

	initial begin
		void'($urandom(32'h5c27_c00a));
		rst_n             <= 1'b0;
		gpio_ext          <= '0;
		gpio_out_core     <= '0;
		gpio_mode0_core   <= '0;
		gpio_mode1_core   <= '0;
		gpio_outenb_core  <= '1;
		gpio_inenb_core   <= '0;
		flash_io_ext      <= '0;
		flash_io_do_core  <= '0;
		flash_io_oeb_core <= '1;
		flash_io_ieb_core <= '0;
		rstb_ext          <= 1'b0;
		mprj_ext          <= '0;
		mprj_io_out       <= '0;
		mprj_io_oeb       <= '1;
		mprj_io_hldh_n    <= '1;
		mprj_io_enh       <= '0;
		mprj_io_inp_dis   <= '0;
		mprj_io_dm        <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_filter();
		test_gpio_modes();
		test_gpio_input();
		test_flash();
		test_mprj_hold();

		sample_after(2);
		if (i_dut.i_chk.assert_fails == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			fail_run("Assertion failures were reported during the run");
		end
	end

endmodule

//--- verilog/chip_io.sv
`timescale 1ns/10ps

module chip_io #(
	parameter int GPIO_SYNC     = 2,
	parameter int FLASH_SYNC    = 1,
	parameter int MPRJ_SYNC     = 2,
	parameter int MPRJ_PADS     = pad_pkg::MPRJ_IO_PADS,
	parameter int FILTER_CYCLES = pad_pkg::XRES_FILTER_CYCLES
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	// GPIO bank
	input  logic [pad_pkg::GPIO_PADS-1:0]         gpio_ext,
	input  logic [pad_pkg::GPIO_PADS-1:0]         gpio_out_core,
	input  logic [pad_pkg::GPIO_PADS-1:0]         gpio_mode0_core,
	input  logic [pad_pkg::GPIO_PADS-1:0]         gpio_mode1_core,
	input  logic [pad_pkg::GPIO_PADS-1:0]         gpio_outenb_core,
	input  logic [pad_pkg::GPIO_PADS-1:0]         gpio_inenb_core,
	output logic [pad_pkg::GPIO_PADS-1:0]         gpio_pad_out,
	output logic [pad_pkg::GPIO_PADS-1:0]         gpio_pad_oe,
	output logic [pad_pkg::GPIO_PADS-1:0]         gpio_in_core,
	// Flash data pads
	input  logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_ext,
	input  logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_do_core,
	input  logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_oeb_core,
	input  logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_ieb_core,
	output logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_pad_out,
	output logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_pad_oe,
	output logic [pad_pkg::FLASH_IO_PADS-1:0]     flash_io_di_core,
	// External reset
	input  logic                                  rstb_ext,
	output logic                                  porb,
	// User-project ring
	input  logic [MPRJ_PADS-1:0]                  mprj_ext,
	input  logic [MPRJ_PADS-1:0]                  mprj_io_out,
	input  logic [MPRJ_PADS-1:0]                  mprj_io_oeb,
	input  logic [MPRJ_PADS-1:0]                  mprj_io_hldh_n,
	input  logic [MPRJ_PADS-1:0]                  mprj_io_enh,
	input  logic [MPRJ_PADS-1:0]                  mprj_io_inp_dis,
	input  logic [MPRJ_PADS*pad_pkg::DM_BITS-1:0] mprj_io_dm,
	output logic [MPRJ_PADS-1:0]                  mprj_pad_out,
	output logic [MPRJ_PADS-1:0]                  mprj_pad_oe,
	output logic [MPRJ_PADS-1:0]                  mprj_io_in
);

	localparam int DMW = pad_pkg::DM_BITS;

	pad_ctrl_if #(.WIDTH(pad_pkg::GPIO_PADS))     gpio_ctrl ();
	pad_ctrl_if #(.WIDTH(pad_pkg::FLASH_IO_PADS)) flash_ctrl ();

	assign gpio_ctrl.out = gpio_out_core;
	assign gpio_ctrl.oeb = gpio_outenb_core;
	assign gpio_ctrl.ieb = gpio_inenb_core;
	assign gpio_in_core  = gpio_ctrl.in;

	assign flash_ctrl.out = flash_io_do_core;
	assign flash_ctrl.oeb = flash_io_oeb_core;
	assign flash_ctrl.ieb = flash_io_ieb_core;
	assign flash_io_di_core = flash_ctrl.in;

	// Two GPIO mode bits widen to the pad code as {mode1, mode1, mode0}
	// Flash mode follows the enables as {ieb, ieb, oeb}
	generate
		for (genvar i = 0; i < pad_pkg::GPIO_PADS; i++) begin : g_gpio_dm
			assign gpio_ctrl.dm[DMW*i +: DMW] =
				{gpio_mode1_core[i], gpio_mode1_core[i], gpio_mode0_core[i]};
		end
		for (genvar i = 0; i < pad_pkg::FLASH_IO_PADS; i++) begin : g_flash_dm
			assign flash_ctrl.dm[DMW*i +: DMW] =
				{flash_io_ieb_core[i], flash_io_ieb_core[i], flash_io_oeb_core[i]};
		end
	endgenerate

	pad_bank #(
		.WIDTH       (pad_pkg::GPIO_PADS),
		.SYNC_STAGES (GPIO_SYNC)
	) i_gpio (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (gpio_ctrl.pad),
		.ext     (gpio_ext),
		.pad_out (gpio_pad_out),
		.pad_oe  (gpio_pad_oe)
	);

	pad_bank #(
		.WIDTH       (pad_pkg::FLASH_IO_PADS),
		.SYNC_STAGES (FLASH_SYNC)
	) i_flash (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (flash_ctrl.pad),
		.ext     (flash_io_ext),
		.pad_out (flash_io_pad_out),
		.pad_oe  (flash_io_pad_oe)
	);

	xres_filter #(
		.FILTER_CYCLES (FILTER_CYCLES)
	) i_xres (
		.clk   (clk),
		.rst_n (rst_n),
		.rstb  (rstb_ext),
		.porb  (porb)
	);

	mprj_io_ring #(
		.PADS        (MPRJ_PADS),
		.SYNC_STAGES (MPRJ_SYNC)
	) i_mprj (
		.clk     (clk),
		.rst_n   (rst_n),
		.ext     (mprj_ext),
		.io_out  (mprj_io_out),
		.io_oeb  (mprj_io_oeb),
		.hldh_n  (mprj_io_hldh_n),
		.enh     (mprj_io_enh),
		.inp_dis (mprj_io_inp_dis),
		.dm      (mprj_io_dm),
		.pad_out (mprj_pad_out),
		.pad_oe  (mprj_pad_oe),
		.io_in   (mprj_io_in)
	);

endmodule

//--- verilog/pad_bank.sv
`timescale 1ns/10ps

module pad_bank #(
	parameter int WIDTH       = 1,
	parameter int SYNC_STAGES = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	pad_ctrl_if.pad          ctrl,
	input  logic [WIDTH-1:0] ext,
	output logic [WIDTH-1:0] pad_out,
	output logic [WIDTH-1:0] pad_oe
);

	// Mode decode results per pad
	logic [WIDTH-1:0] drive_en;
	logic [WIDTH-1:0] in_en;

	logic [WIDTH-1:0] pad_level;
	logic [WIDTH-1:0] raw_in;

	always_comb begin
		pad_pkg::pad_dm_e mode;

		drive_en = '0;
		in_en    = '0;
		for (int i = 0; i < WIDTH; i++) begin
			mode = pad_pkg::pad_dm_e'(ctrl.dm[pad_pkg::DM_BITS*i +: pad_pkg::DM_BITS]);
			case (mode)
				pad_pkg::PAD_DM_INPUT: begin
					in_en[i] = 1'b1;
				end
				// Open drain only ever pulls low
				pad_pkg::PAD_DM_OPEN_DRAIN: begin
					in_en[i]    = 1'b1;
					drive_en[i] = ~ctrl.out[i];
				end
				pad_pkg::PAD_DM_STRONG,
				pad_pkg::PAD_DM_STRONG_SLOW: begin
					in_en[i]    = 1'b1;
					drive_en[i] = 1'b1;
				end
				default: begin
					in_en[i]    = 1'b0;
					drive_en[i] = 1'b0;
				end
			endcase
		end
	end

	// Output disable overrides any drive mode
	assign pad_oe  = drive_en & ~ctrl.oeb;
	assign pad_out = ctrl.out;

	// Our own drive wins over the board value on the pad
	assign pad_level = (pad_oe & ctrl.out) | (~pad_oe & ext);

	// Input buffer is off when disabled or in mode off
	assign raw_in = pad_level & in_en & ~ctrl.ieb;

	generate
		if (SYNC_STAGES == 0) begin : g_no_sync
			assign ctrl.in = raw_in;
		end else begin : g_sync
			logic [WIDTH-1:0] sync_q [SYNC_STAGES];

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					for (int s = 0; s < SYNC_STAGES; s++) begin
						sync_q[s] <= '0;
					end
				end else begin
					sync_q[0] <= raw_in;
					for (int s = 1; s < SYNC_STAGES; s++) begin
						sync_q[s] <= sync_q[s-1];
					end
				end
			end

			assign ctrl.in = sync_q[SYNC_STAGES-1];
		end
	endgenerate

endmodule

//--- verilog/xres_filter.sv
`timescale 1ns/10ps

module xres_filter #(
	parameter int FILTER_CYCLES = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic rstb,
	output logic porb
);

	// Counter wide enough to reach FILTER_CYCLES
	localparam int CNT_W = $clog2(FILTER_CYCLES + 1);

	// Two flops bring the board pin into the clock domain
	logic [1:0] rstb_sync;

	logic [CNT_W-1:0] stable_cnt;
	logic             level_differs;
	logic             count_done;

	assign level_differs = rstb_sync[1] ^ porb;
	assign count_done    = (stable_cnt == CNT_W'(FILTER_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rstb_sync <= 2'b00;
		end else begin
			rstb_sync <= {rstb_sync[0], rstb};
		end
	end

	// Persistence filter
	// porb only follows a level that stays put for FILTER_CYCLES cycles
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stable_cnt <= '0;
			porb       <= 1'b0;
		end else if (!level_differs) begin
			// Glitch ended early so the count starts over
			stable_cnt <= '0;
		end else if (count_done) begin
			porb       <= rstb_sync[1];
			stable_cnt <= '0;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule
